//--- mdu_pkg.sv
`default_nettype none

package mdu_pkg;

  localparam int XLEN      = 32;
  localparam int TAG_W     = 4;
  localparam int NUM_LANES = 4;
  localparam int LANE_W    = 2;         // Lane index, NUM_LANES is a power of two
  localparam int DIV_STEPS = 32;        // One quotient bit per step
  localparam int CNT_W     = 5;         // Holds DIV_STEPS-1
  localparam int PROD_W    = 2 * XLEN;  // Full product width

  // Most negative signed operand
  localparam logic [XLEN-1:0] XLEN_MIN = {1'b1, {(XLEN-1){1'b0}}};

  typedef enum logic [2:0] {
    OP_MUL    = 3'd0,
    OP_MULH   = 3'd1,
    OP_MULHSU = 3'd2,
    OP_MULHU  = 3'd3,
    OP_DIV    = 3'd4,
    OP_DIVU   = 3'd5,
    OP_REM    = 3'd6,
    OP_REMU   = 3'd7
  } mdu_op_e;

  // Upper half of the opcode space goes to the divider
  function automatic logic op_is_div(mdu_op_e op);
    return op[2];
  endfunction

  function automatic logic op_is_signed_div(mdu_op_e op);
    return (op == OP_DIV) || (op == OP_REM);
  endfunction

  function automatic logic op_is_rem(mdu_op_e op);
    return (op == OP_REM) || (op == OP_REMU);
  endfunction

endpackage

`default_nettype wire

//--- mdu_dispatch.sv
`timescale 1ns/1ns
`default_nettype none

module mdu_dispatch (
  input  wire                           i_clk,
  input  wire                           i_rst,
  input  wire                           i_valid,
  input  wire [mdu_pkg::XLEN-1:0]       i_rs1,
  input  wire [mdu_pkg::XLEN-1:0]       i_rs2,
  input  var  mdu_pkg::mdu_op_e         i_op,
  input  wire [mdu_pkg::TAG_W-1:0]      i_tag,
  input  wire [mdu_pkg::NUM_LANES-1:0]  i_lane_busy,
  output logic                          o_busy,
  output logic [mdu_pkg::NUM_LANES-1:0] o_lane_start,
  output logic [mdu_pkg::XLEN-1:0]      o_rs1,
  output logic [mdu_pkg::XLEN-1:0]      o_rs2,
  output mdu_pkg::mdu_op_e              o_op,
  output logic [mdu_pkg::TAG_W-1:0]     o_tag
);
  import mdu_pkg::*;

  logic [NUM_LANES-1:0] lane_occupied;
  logic [LANE_W-1:0]    free_idx;
  logic                 accept;

  assign lane_occupied = i_lane_busy | o_lane_start;  // Start in flight holds the lane
  assign o_busy        = &lane_occupied;
  assign accept        = i_valid && !o_busy;

  // Lowest-numbered free lane wins
  always_comb begin
    free_idx = '0;
    for (int k = NUM_LANES - 1; k >= 0; k--) begin
      if (!lane_occupied[k]) begin
        free_idx = LANE_W'(k);
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_lane_start <= '0;
    end else begin
      o_lane_start <= '0;
      if (accept) begin
        o_lane_start[free_idx] <= 1'b1;  // Single-cycle strobe
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (accept) begin
      o_rs1 <= i_rs1;
      o_rs2 <= i_rs2;
      o_op  <= i_op;
      o_tag <= i_tag;
    end
  end

  a_no_valid_when_busy : assert property (@(posedge i_clk) disable iff (i_rst)
    i_valid |-> !o_busy)
    else $error("request strobe while the cluster is busy");

  a_start_onehot : assert property (@(posedge i_clk) disable iff (i_rst)
    $onehot0(o_lane_start) && ((o_lane_start & i_lane_busy) == '0))
    else $error("lane start not one-hot or sent to a busy lane");

endmodule

`default_nettype wire

//--- mdu_divider.sv
`timescale 1ns/1ns
`default_nettype none

module mdu_divider (
  input  wire                      i_clk,
  input  wire                      i_rst,
  input  wire                      i_start,
  input  wire [mdu_pkg::XLEN-1:0]  i_rs1,
  input  wire [mdu_pkg::XLEN-1:0]  i_rs2,
  input  var  mdu_pkg::mdu_op_e    i_op,
  output logic                     o_done,
  output logic [mdu_pkg::XLEN-1:0] o_quot,
  output logic [mdu_pkg::XLEN-1:0] o_rem
);
  import mdu_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_RUN,
    ST_FIX
  } div_state_e;

  div_state_e       state;
  logic [CNT_W-1:0] cnt;
  logic [XLEN-1:0]  part_rem;
  logic [XLEN-1:0]  quot;      // Dividend shifts out as quotient bits shift in
  logic [XLEN-1:0]  divisor;
  logic [XLEN-1:0]  dividend;  // Raw rs1 for the corner cases
  logic             neg_quot;
  logic             neg_rem;
  logic             div_zero;
  logic             overflow;
  logic             sgn;
  logic [XLEN:0]    shifted;
  logic [XLEN:0]    trial;

  assign sgn     = op_is_signed_div(i_op);
  assign shifted = {part_rem, quot[XLEN-1]};
  assign trial   = shifted - {1'b0, divisor};  // MSB set means divisor does not fit

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state  <= ST_IDLE;
      cnt    <= '0;
      o_done <= 1'b0;
    end else begin
      o_done <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (i_start) begin
            state <= ST_RUN;
            cnt   <= CNT_W'(DIV_STEPS - 1);
          end
        end
        ST_RUN: begin
          if (cnt == '0) begin
            state <= ST_FIX;
          end else begin
            cnt <= cnt - 1'b1;
          end
        end
        ST_FIX: begin
          state  <= ST_IDLE;
          o_done <= 1'b1;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    case (state)
      ST_IDLE: begin
        if (i_start) begin
          part_rem <= '0;
          quot     <= (sgn && i_rs1[XLEN-1]) ? -i_rs1 : i_rs1;  // Magnitudes
          divisor  <= (sgn && i_rs2[XLEN-1]) ? -i_rs2 : i_rs2;
          dividend <= i_rs1;
          neg_quot <= sgn && (i_rs1[XLEN-1] ^ i_rs2[XLEN-1]);
          neg_rem  <= sgn && i_rs1[XLEN-1];
          div_zero <= (i_rs2 == '0);
          overflow <= sgn && (i_rs1 == XLEN_MIN) && (i_rs2 == '1);
        end
      end
      ST_RUN: begin
        if (trial[XLEN]) begin
          part_rem <= shifted[XLEN-1:0];
          quot     <= {quot[XLEN-2:0], 1'b0};
        end else begin
          part_rem <= trial[XLEN-1:0];
          quot     <= {quot[XLEN-2:0], 1'b1};
        end
      end
      ST_FIX: begin
        if (div_zero) begin
          o_quot <= '1;
          o_rem  <= dividend;
        end else if (overflow) begin
          o_quot <= dividend;
          o_rem  <= '0;
        end else begin
          o_quot <= neg_quot ? -quot : quot;
          o_rem  <= neg_rem ? -part_rem : part_rem;  // Remainder follows dividend
        end
      end
      default: begin
      end
    endcase
  end

  a_start_in_idle : assert property (@(posedge i_clk) disable iff (i_rst)
    i_start |-> state == ST_IDLE)
    else $error("divider started while running");

endmodule

`default_nettype wire

//--- mdu_lane.sv
`timescale 1ns/1ns
`default_nettype none

module mdu_lane (
  input  wire                      i_clk,
  input  wire                      i_rst,
  input  wire                      i_start,
  input  wire [mdu_pkg::XLEN-1:0]  i_rs1,
  input  wire [mdu_pkg::XLEN-1:0]  i_rs2,
  input  var  mdu_pkg::mdu_op_e    i_op,
  input  wire [mdu_pkg::TAG_W-1:0] i_tag,
  input  wire                      i_taken,
  output logic                     o_busy,
  output logic                     o_done,
  output logic [mdu_pkg::XLEN-1:0] o_rd,
  output logic [mdu_pkg::TAG_W-1:0] o_tag
);
  import mdu_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_MUL,
    ST_DIV,
    ST_DONE
  } lane_state_e;

  lane_state_e              state;
  logic [XLEN-1:0]          rs1_q;
  logic [XLEN-1:0]          rs2_q;
  mdu_op_e                  op_q;
  logic                     div_start;
  logic                     div_done;
  logic [XLEN-1:0]          div_quot;
  logic [XLEN-1:0]          div_rem;
  logic signed [XLEN:0]     mul_a;
  logic signed [XLEN:0]     mul_b;
  logic signed [PROD_W+1:0] product;

  assign mul_a   = {(op_q != OP_MULHU) && rs1_q[XLEN-1], rs1_q};  // Low half ignores signs
  assign mul_b   = {(op_q == OP_MULH) && rs2_q[XLEN-1], rs2_q};
  assign product = mul_a * mul_b;

  assign o_busy = (state != ST_IDLE);
  assign o_done = (state == ST_DONE);

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state     <= ST_IDLE;
      div_start <= 1'b0;
    end else begin
      div_start <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (i_start) begin
            state     <= op_is_div(i_op) ? ST_DIV : ST_MUL;
            div_start <= op_is_div(i_op);  // Divider sees operands a cycle later
          end
        end
        ST_MUL: state <= ST_DONE;
        ST_DIV: begin
          if (div_done) begin
            state <= ST_DONE;
          end
        end
        ST_DONE: begin
          if (i_taken) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (state == ST_IDLE && i_start) begin
      rs1_q <= i_rs1;
      rs2_q <= i_rs2;
      op_q  <= i_op;
      o_tag <= i_tag;
    end
    if (state == ST_MUL) begin
      o_rd <= (op_q == OP_MUL) ? product[XLEN-1:0] : product[PROD_W-1:XLEN];
    end else if (state == ST_DIV && div_done) begin
      o_rd <= op_is_rem(op_q) ? div_rem : div_quot;
    end
  end

  mdu_divider divider_inst (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_start (div_start),
    .i_rs1   (rs1_q),
    .i_rs2   (rs2_q),
    .i_op    (op_q),
    .o_done  (div_done),
    .o_quot  (div_quot),
    .o_rem   (div_rem)
  );

  a_taken_in_done : assert property (@(posedge i_clk) disable iff (i_rst)
    i_taken |-> state == ST_DONE)
    else $error("lane result taken while not done");

endmodule

`default_nettype wire

//--- mdu_collect.sv
`timescale 1ns/1ns
`default_nettype none

module mdu_collect (
  input  wire                           i_clk,
  input  wire                           i_rst,
  input  wire [mdu_pkg::NUM_LANES-1:0]  i_lane_done,
  input  wire [mdu_pkg::XLEN-1:0]       i_lane_rd [mdu_pkg::NUM_LANES],
  input  wire [mdu_pkg::TAG_W-1:0]      i_lane_tag [mdu_pkg::NUM_LANES],
  output logic [mdu_pkg::NUM_LANES-1:0] o_lane_taken,
  output logic                          o_valid,
  output logic [mdu_pkg::XLEN-1:0]      o_rd,
  output logic [mdu_pkg::TAG_W-1:0]     o_tag
);
  import mdu_pkg::*;

  logic [LANE_W-1:0] last_q;   // Lane served most recently
  logic [LANE_W-1:0] win_idx;
  logic              win;

  // Walk from farthest to nearest so the lane right after last_q wins
  always_comb begin
    win     = 1'b0;
    win_idx = last_q;
    for (int i = NUM_LANES; i >= 1; i--) begin
      if (i_lane_done[LANE_W'(int'(last_q) + i)]) begin
        win     = 1'b1;
        win_idx = LANE_W'(int'(last_q) + i);  // Wraps modulo NUM_LANES
      end
    end
    o_lane_taken          = '0;
    o_lane_taken[win_idx] = win;
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_valid <= 1'b0;
      last_q  <= LANE_W'(NUM_LANES - 1);  // First search starts at lane 0
    end else begin
      o_valid <= win;
      if (win) begin
        last_q <= win_idx;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (win) begin
      o_rd  <= i_lane_rd[win_idx];
      o_tag <= i_lane_tag[win_idx];
    end
  end

  a_taken_onehot : assert property (@(posedge i_clk) disable iff (i_rst)
    $onehot0(o_lane_taken) && ((i_lane_done & $past(o_lane_taken)) == '0))
    else $error("taken strobe not one-hot or lane still done after taken");

endmodule

`default_nettype wire

//--- mdu_cluster.sv
`timescale 1ns/1ns
`default_nettype none

module mdu_cluster (
  input  wire                       i_clk,
  input  wire                       i_rst,
  input  wire                       i_valid,
  input  wire [mdu_pkg::XLEN-1:0]   i_rs1,
  input  wire [mdu_pkg::XLEN-1:0]   i_rs2,
  input  var  mdu_pkg::mdu_op_e     i_op,
  input  wire [mdu_pkg::TAG_W-1:0]  i_tag,
  output logic                      o_busy,
  output logic                      o_valid,
  output logic [mdu_pkg::XLEN-1:0]  o_rd,
  output logic [mdu_pkg::TAG_W-1:0] o_tag
);
  import mdu_pkg::*;

  wire [NUM_LANES-1:0] lane_start;
  wire [NUM_LANES-1:0] lane_busy;
  wire [NUM_LANES-1:0] lane_done;
  wire [NUM_LANES-1:0] lane_taken;
  wire [XLEN-1:0]      disp_rs1;
  wire [XLEN-1:0]      disp_rs2;
  mdu_op_e             disp_op;
  wire [TAG_W-1:0]     disp_tag;
  wire [XLEN-1:0]      lane_rd [NUM_LANES];
  wire [TAG_W-1:0]     lane_tag [NUM_LANES];

  mdu_dispatch dispatch_inst (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_valid      (i_valid),
    .i_rs1        (i_rs1),
    .i_rs2        (i_rs2),
    .i_op         (i_op),
    .i_tag        (i_tag),
    .i_lane_busy  (lane_busy),
    .o_busy       (o_busy),
    .o_lane_start (lane_start),
    .o_rs1        (disp_rs1),
    .o_rs2        (disp_rs2),
    .o_op         (disp_op),
    .o_tag        (disp_tag)
  );

  // Operand bus is shared, only the started lane latches it
  for (genvar k = 0; k < NUM_LANES; k++) begin : g_lane
    mdu_lane lane_inst (
      .i_clk   (i_clk),
      .i_rst   (i_rst),
      .i_start (lane_start[k]),
      .i_rs1   (disp_rs1),
      .i_rs2   (disp_rs2),
      .i_op    (disp_op),
      .i_tag   (disp_tag),
      .i_taken (lane_taken[k]),
      .o_busy  (lane_busy[k]),
      .o_done  (lane_done[k]),
      .o_rd    (lane_rd[k]),
      .o_tag   (lane_tag[k])
    );
  end

  mdu_collect collect_inst (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_lane_done  (lane_done),
    .i_lane_rd    (lane_rd),
    .i_lane_tag   (lane_tag),
    .o_lane_taken (lane_taken),
    .o_valid      (o_valid),
    .o_rd         (o_rd),
    .o_tag        (o_tag)
  );

endmodule

`default_nettype wire

//--- tb_mdu_cluster.sv
`timescale 1ns/1ns
`default_nettype none

module tb_mdu_cluster;
  import mdu_pkg::*;

  localparam int WAIT_LIMIT  = 200;
  localparam int DRAIN_LIMIT = 600;
  localparam int NUM_TAGS    = 1 << TAG_W;
  localparam logic [XLEN-1:0] CORNERS [6] = '{32'h0000_0000, 32'h0000_0001, 32'hFFFF_FFFF,
                                              32'h8000_0000, 32'h7FFF_FFFF, 32'h0000_0007};

  logic             i_clk = 1'b0;
  logic             i_rst;
  logic             i_valid;
  logic [XLEN-1:0]  i_rs1;
  logic [XLEN-1:0]  i_rs2;
  mdu_op_e          i_op;
  logic [TAG_W-1:0] i_tag;
  wire              o_busy;
  wire              o_valid;
  wire [XLEN-1:0]   o_rd;
  wire [TAG_W-1:0]  o_tag;

  logic [XLEN-1:0]  exp_rd [NUM_TAGS];
  logic [7:0]       iss_cnt [NUM_TAGS] = '{default: 8'd0};  // Stimulus side
  logic [7:0]       ret_cnt [NUM_TAGS] = '{default: 8'd0};  // Checker side
  logic [TAG_W-1:0] next_tag = '0;
  logic             started = 1'b0;
  logic             abort = 1'b0;
  int               seed = 25193;
  int               chk_errors = 0;
  int               seq_errors = 0;
  int               tests_ok = 0;
  int               tests_bad = 0;

  always #10 i_clk = ~i_clk;

  mdu_cluster mdu_cluster_inst (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_valid (i_valid),
    .i_rs1   (i_rs1),
    .i_rs2   (i_rs2),
    .i_op    (i_op),
    .i_tag   (i_tag),
    .o_busy  (o_busy),
    .o_valid (o_valid),
    .o_rd    (o_rd),
    .o_tag   (o_tag)
  );

  // RISC-V M results, straight from the spec
  function automatic logic [XLEN-1:0] ref_result(mdu_op_e op, logic [XLEN-1:0] a,
                                                 logic [XLEN-1:0] b);
    longint          sa;
    longint          sb;
    longint          ub;
    int              qa;
    int              qb;
    logic [63:0]     prod;
    logic [XLEN-1:0] res;
    logic            ovf;
    sa   = longint'($signed(a));
    sb   = longint'($signed(b));
    ub   = longint'({32'd0, b});
    qa   = $signed(a);
    qb   = $signed(b);
    ovf  = (a == 32'h8000_0000) && (b == 32'hFFFF_FFFF);
    prod = {32'd0, a} * {32'd0, b};
    case (op)
      OP_MUL:    res = prod[31:0];
      OP_MULH:   res = 32'(64'(sa * sb) >> 32);
      OP_MULHSU: res = 32'(64'(sa * ub) >> 32);
      OP_MULHU:  res = prod[63:32];
      OP_DIV: begin
        if (b == '0) begin
          res = '1;
        end else if (ovf) begin
          res = a;
        end else begin
          res = qa / qb;  // Signed, truncates toward zero
        end
      end
      OP_DIVU:   res = (b == '0) ? '1 : a / b;
      OP_REM: begin
        if (b == '0) begin
          res = a;
        end else if (ovf) begin
          res = '0;
        end else begin
          res = qa % qb;
        end
      end
      default:   res = (b == '0) ? a : a % b;
    endcase
    return res;
  endfunction

  function automatic logic is_pending(int t);
    return iss_cnt[t] != ret_cnt[t];
  endfunction

  function automatic logic any_pending();
    logic p;
    p = 1'b0;
    for (int t = 0; t < NUM_TAGS; t++) begin
      p = p | is_pending(t);
    end
    return p;
  endfunction

  function automatic logic [TAG_W-1:0] free_tag();
    logic [TAG_W-1:0] t;
    t = next_tag;
    for (int i = 0; i < NUM_TAGS; i++) begin
      if (is_pending(int'(t))) begin
        t = t + 1'b1;
      end
    end
    return t;
  endfunction

  always @(posedge i_clk) begin
    if (!i_rst) begin
      if (!started) begin
        assert (!o_valid && !o_busy) else begin
          $display("MISMATCH at %0t: o_valid/o_busy expected 0/0 actual %0b/%0b",
                   $time, o_valid, o_busy);
          chk_errors++;
        end
      end
      if (o_valid) begin
        assert (is_pending(int'(o_tag))) else begin
          $display("At %0t tag %0d came back without being outstanding", $time, o_tag);
          chk_errors++;
        end
        assert (o_rd == exp_rd[o_tag]) else begin
          $display("MISMATCH at %0t: o_rd expected %08h actual %08h (tag %0d)",
                   $time, exp_rd[o_tag], o_rd, o_tag);
          chk_errors++;
        end
        if (is_pending(int'(o_tag))) begin
          ret_cnt[o_tag] = ret_cnt[o_tag] + 8'd1;
        end
      end
    end
  end

  task automatic wait_not_busy();
    int n;
    n = 0;
    while (o_busy && !abort) begin
      if (n == WAIT_LIMIT) begin
        $display("Timeout: o_busy stayed high for %0d cycles", WAIT_LIMIT);
        abort = 1'b1;
        seq_errors++;
      end else begin
        @(negedge i_clk);
        n++;
      end
    end
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (any_pending() && !abort) begin
      if (n == DRAIN_LIMIT) begin
        $display("Timeout: results still outstanding after %0d cycles", DRAIN_LIMIT);
        abort = 1'b1;
        seq_errors++;
      end else begin
        @(negedge i_clk);
        n++;
      end
    end
  endtask

  // Called on a falling edge, returns one cycle later
  task automatic issue(input mdu_op_e op, input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
    logic [TAG_W-1:0] t;
    wait_not_busy();
    if (!abort) begin
      t          = free_tag();
      exp_rd[t]  = ref_result(op, a, b);
      iss_cnt[t] = iss_cnt[t] + 8'd1;
      next_tag   = t + 1'b1;
      started    = 1'b1;
      i_valid    = 1'b1;
      i_op       = op;
      i_rs1      = a;
      i_rs2      = b;
      i_tag      = t;
      @(negedge i_clk);
      i_valid = 1'b0;
    end
  endtask

  task automatic report(input string name, input int err_before);
    int errs;
    errs = chk_errors + seq_errors - err_before;
    if (errs == 0) begin
      $display("[%s] ok at %0t", name, $time);
      tests_ok++;
    end else begin
      $display("[%s] failed with %0d errors", name, errs);
      tests_bad++;
    end
  endtask

  initial begin
    int              err0;
    logic [XLEN-1:0] b;
    i_rst   = 1'b1;
    i_valid = 1'b0;
    i_rs1   = '0;
    i_rs2   = '0;
    i_op    = OP_MUL;
    i_tag   = '0;
    repeat (16) @(negedge i_clk);
    i_rst = 1'b0;

    err0 = chk_errors + seq_errors;
    repeat (8) @(negedge i_clk);  // Idle window
    report("reset idle", err0);

    for (int g = 0; g < 2; g++) begin  // Multiplies, then divides
      err0 = chk_errors + seq_errors;
      for (int k = 0; k < 4; k++) begin
        for (int i = 0; i < 6; i++) begin
          for (int j = 0; j < 6; j++) begin
            issue(mdu_op_e'(3'(4 * g + k)), CORNERS[i], CORNERS[j]);
          end
        end
        repeat (6) issue(mdu_op_e'(3'(4 * g + k)), $random(seed), $random(seed));
      end
      wait_drain();
      report((g == 0) ? "multiply" : "divide", err0);
    end

    err0 = chk_errors + seq_errors;
    for (int n = 0; n < 80; n++) begin
      b = $random(seed);
      if (b[2:0] == 3'd0) begin
        b = '0;  // Some zero divisors
      end
      issue(mdu_op_e'(3'($random(seed))), $random(seed), b);
    end
    wait_drain();
    report("back to back", err0);

    err0 = chk_errors + seq_errors;
    for (int k = 0; k < NUM_LANES; k++) begin
      issue(mdu_op_e'(3'(k + 4)), $random(seed), $random(seed));
    end
    if (!abort) begin
      assert (o_busy) else begin
        $display("MISMATCH at %0t: o_busy expected 1 actual %0b", $time, o_busy);
        seq_errors++;
      end
    end
    wait_not_busy();
    issue(OP_MULHU, $random(seed), $random(seed));
    wait_drain();
    report("saturation", err0);

    $display("tests ok: %0d, tests failed: %0d", tests_ok, tests_bad);
    if (tests_bad == 0 && !abort) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb.f
mdu_pkg.sv
mdu_dispatch.sv
mdu_divider.sv
mdu_lane.sv
mdu_collect.sv
mdu_cluster.sv
tb_mdu_cluster.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and grade the run from its log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module tb_mdu_cluster \
  -o sim_mdu_cluster > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "Verilator build failed, see build.log"
  exit 1
fi

./obj_dir/sim_mdu_cluster > sim.log 2>&1
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status, see sim.log"
  exit 1
fi

if grep -qx "TEST PASS" sim.log; then
  echo "Simulation passed"
  exit 0
fi
echo "Simulation failed, see sim.log"
exit 1
